// File: dbg_ahb_pkg.sv
/* AHB-Lite encodings used by the debug bridge master
   Transfer type, size, burst and protection codes plus bus widths */

package dbg_ahb_pkg;

  ////////////////////
  // Bus widths

  localparam int ahb_aw = 32;
  localparam int ahb_dw = 32;

  ////////////////////
  // HTRANS codes
  // BUSY and SEQ are never issued, only singles
  localparam logic [1:0] htrans_idle   = 2'b00;
  localparam logic [1:0] htrans_nonseq = 2'b10;

  ////////////////////
  // HSIZE codes, one per access width
  localparam logic [2:0] hsize_byte = 3'b000;
  localparam logic [2:0] hsize_half = 3'b001;
  localparam logic [2:0] hsize_word = 3'b010;

  // Single transfers only
  localparam logic [2:0] hburst_single = 3'b000;

  // HPROT bits: [0] data, [1] privileged, [2] bufferable, [3] cacheable
  localparam logic [3:0] hprot_dbg = 4'b0011;

endpackage

// File: dbg_bus_pkg.sv
/* Debug controller port definitions */

package dbg_bus_pkg;

  ////////////////////
  // Port widths

  localparam int bb_aw = 32;
  localparam int bb_dw = 32;

  // Access width from the debug controller, counted in bytes
  typedef logic [3:0] bb_size_t;

  ////////////////////
  // Word size codes
  localparam bb_size_t ws_byte = 4'd1;
  localparam bb_size_t ws_half = 4'd2;
  localparam bb_size_t ws_word = 4'd4;

  ////////////////////
  // Lane layout
  // Little-endian: byte lane n sits in data bits [8n+7:8n]
  // and is selected by address bits [1:0] == n
  localparam int lanes = 4;

endpackage

// File: dbg_xfer_if.sv
/* Access fields and result passed between the tck and HCLK domains */

`timescale 1ns/1ps

interface dbg_xfer_if;

  ////////////////////
  // Request, tck domain
  // Held stable from the start toggle until ready comes back

  logic [dbg_bus_pkg::bb_aw-1:0]  addr;
  logic [dbg_ahb_pkg::ahb_dw-1:0] wdata;
  logic                           write;
  // AHB size code, already mapped from the debug word size
  logic [2:0]                     size;
  logic                           start_tgl;

  ////////////////////
  // Result, HCLK domain
  // Written together with the done toggle flip

  logic [dbg_bus_pkg::bb_dw-1:0]  rdata;
  logic                           err;
  logic                           done_tgl;

  // Debug clock side latches requests
  modport tck_side (
    output addr, wdata, write, size, start_tgl,
    input  rdata, err, done_tgl
  );

  // AHB side performs the transfer and reports back
  modport ahb_side (
    input  addr, wdata, write, size, start_tgl,
    output rdata, err, done_tgl
  );

endinterface

// File: dbg_toggle_sync.sv
/* Toggle synchronizer, one destination-clock pulse per toggle edge */

`timescale 1ns/1ps

module dbg_toggle_sync (
  input  logic clk,
  input  logic ahb_rstn,
  input  logic tgl,
  output logic pulse
);

  // Two metastability stages and one delayed copy
  logic meta_q;
  logic sync_q;
  logic last_q;

  always_ff @(posedge clk or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      meta_q <= 1'b0;
      sync_q <= 1'b0;
      last_q <= 1'b0;
    end else begin
      meta_q <= tgl;
      sync_q <= meta_q;
      last_q <= sync_q;
    end
  end

  // Either edge of the toggle gives one cycle
  assign pulse = sync_q ^ last_q;

endmodule

// File: dbg_bb_capture.sv
/* Debug clock side of the bridge
   Latches an access, starts it by toggle and drives ready */

`timescale 1ns/1ps

module dbg_bb_capture (
  input  logic                          tck,
  input  logic                          ahb_rstn,
  input  logic                          bb_strb,
  input  logic                          bb_rw,
  input  logic [dbg_bus_pkg::bb_aw-1:0] bb_addr,
  input  logic [dbg_bus_pkg::bb_dw-1:0] bb_di,
  input  dbg_bus_pkg::bb_size_t         bb_word_size,
  input  logic                          done_pulse,
  output logic                          bb_rdy,
  dbg_xfer_if.tck_side                  x
);

  logic [1:0] rst_q;
  logic       rstn_t;
  logic       accept;

  ////////////////////
  // Reset release
  // Asserts at once, lifts two tck edges later
  always_ff @(posedge tck or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      rst_q <= 2'b00;
    end else begin
      rst_q <= {rst_q[0], 1'b1};
    end
  end

  assign rstn_t = rst_q[1];

  // Strobe counts only while idle
  assign accept = bb_strb & bb_rdy;

  ////////////////////
  // Access payload
  // Narrow writes go out on every lane, slave picks by address
  always_ff @(posedge tck) begin
    if (accept) begin
      x.addr <= bb_addr;
      case (bb_word_size)
        dbg_bus_pkg::ws_byte: x.wdata <= {dbg_bus_pkg::lanes{bb_di[7:0]}};
        dbg_bus_pkg::ws_half: x.wdata <= {(dbg_bus_pkg::lanes / 2){bb_di[15:0]}};
        default:              x.wdata <= bb_di;
      endcase
    end
  end

  ////////////////////
  // Control fields
  always_ff @(posedge tck or negedge rstn_t) begin
    if (!rstn_t) begin
      x.write     <= 1'b0;
      x.size      <= dbg_ahb_pkg::hsize_word;
      x.start_tgl <= 1'b0;
      bb_rdy      <= 1'b1;
    end else if (accept) begin
      // bb_rw high means read
      x.write     <= ~bb_rw;
      x.start_tgl <= ~x.start_tgl;
      bb_rdy      <= 1'b0;
      // Unknown codes fall back to a full word
      case (bb_word_size)
        dbg_bus_pkg::ws_byte: x.size <= dbg_ahb_pkg::hsize_byte;
        dbg_bus_pkg::ws_half: x.size <= dbg_ahb_pkg::hsize_half;
        dbg_bus_pkg::ws_word: x.size <= dbg_ahb_pkg::hsize_word;
        default:              x.size <= dbg_ahb_pkg::hsize_word;
      endcase
    end else if (done_pulse) begin
      // Result fields are settled once the done toggle is seen here
      bb_rdy <= 1'b1;
    end
  end

endmodule

// File: dbg_ahb_master.sv
/* AHB-Lite single-transfer master of the debug bridge
   Runs one access per start pulse and returns data, error and a done toggle */

`timescale 1ns/1ps

module dbg_ahb_master (
  input  logic                           HCLK,
  input  logic                           ahb_rstn,
  input  logic                           start_pulse,
  dbg_xfer_if.ahb_side                   x,
  output logic [dbg_ahb_pkg::ahb_aw-1:0] HADDR,
  output logic [dbg_ahb_pkg::ahb_dw-1:0] HWDATA,
  output logic                           HWRITE,
  output logic [2:0]                     HSIZE,
  output logic [1:0]                     HTRANS,
  input  logic [dbg_ahb_pkg::ahb_dw-1:0] HRDATA,
  input  logic                           HREADY,
  input  logic                           HRESP
);

  typedef enum logic [1:0] {
    st_idle,
    st_addr,
    st_data
  } state_t;

  state_t                        state;
  logic [1:0]                    rst_q;
  logic                          rstn_h;
  logic                          pend;
  logic                          ack;
  logic [dbg_bus_pkg::bb_dw-1:0] lane_data;

  ////////////////////
  // Reset release into HCLK
  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      rst_q <= 2'b00;
    end else begin
      rst_q <= {rst_q[0], 1'b1};
    end
  end

  assign rstn_h = rst_q[1];

  // Address phase fields come straight from the latched request
  assign HADDR  = x.addr;
  assign HWRITE = x.write;
  assign HSIZE  = x.size;
  // Request is stable through the data phase as well
  assign HWDATA = x.wdata;

  // Data phase completes on the first HREADY high
  assign ack = HREADY && (state == st_data);

  ////////////////////
  // Transfer FSM
  always_ff @(posedge HCLK or negedge rstn_h) begin
    if (!rstn_h) begin
      state  <= st_idle;
      HTRANS <= dbg_ahb_pkg::htrans_idle;
      pend   <= 1'b0;
    end else begin
      // Start seen while busy waits for the return to idle
      if (state == st_idle) begin
        pend <= 1'b0;
      end else if (start_pulse) begin
        pend <= 1'b1;
      end
      case (state)
        st_idle: begin
          if (start_pulse || pend) begin
            HTRANS <= dbg_ahb_pkg::htrans_nonseq;
            state  <= st_addr;
          end
        end
        st_addr: begin
          // NONSEQ for one cycle only
          HTRANS <= dbg_ahb_pkg::htrans_idle;
          state  <= st_data;
        end
        st_data: begin
          if (HREADY) begin
            state <= st_idle;
          end
        end
        default: begin
          HTRANS <= dbg_ahb_pkg::htrans_idle;
          state  <= st_idle;
        end
      endcase
    end
  end

  ////////////////////
  // Read lane select, little-endian, zero-extended
  always_comb begin
    lane_data = HRDATA;
    case (x.size)
      dbg_ahb_pkg::hsize_byte:
        lane_data = {{(dbg_bus_pkg::bb_dw - 8){1'b0}}, HRDATA[8 * x.addr[1:0] +: 8]};
      dbg_ahb_pkg::hsize_half:
        lane_data = {{(dbg_bus_pkg::bb_dw - 16){1'b0}}, HRDATA[16 * x.addr[1] +: 16]};
      default:
        lane_data = HRDATA;
    endcase
  end

  always_ff @(posedge HCLK) begin
    if (ack) begin
      x.rdata <= lane_data;
    end
  end

  // Error and done flip on the same edge as the data capture
  always_ff @(posedge HCLK or negedge rstn_h) begin
    if (!rstn_h) begin
      x.err      <= 1'b0;
      x.done_tgl <= 1'b0;
    end else if (ack) begin
      x.err      <= HRESP;
      x.done_tgl <= ~x.done_tgl;
    end
  end

endmodule

// File: dbg_ahb_bridge.sv
/* Debug bus to AHB-Lite bridge top
   Carries single debug accesses from tck into HCLK and back */

`timescale 1ns/1ps

module dbg_ahb_bridge (
  input  logic                           HCLK,
  input  logic                           tck,
  input  logic                           ahb_rstn,
  // Debug controller port
  input  logic                           bb_strb,
  input  logic                           bb_rw,
  input  logic [dbg_bus_pkg::bb_aw-1:0]  bb_addr,
  input  logic [dbg_bus_pkg::bb_dw-1:0]  bb_di,
  input  dbg_bus_pkg::bb_size_t          bb_word_size,
  output logic                           bb_rdy,
  output logic [dbg_bus_pkg::bb_dw-1:0]  bb_do,
  output logic                           bb_err,
  // AHB-Lite master
  output logic                           HSEL,
  output logic [dbg_ahb_pkg::ahb_aw-1:0] HADDR,
  output logic [dbg_ahb_pkg::ahb_dw-1:0] HWDATA,
  output logic                           HWRITE,
  output logic [2:0]                     HSIZE,
  output logic [2:0]                     HBURST,
  output logic [3:0]                     HPROT,
  output logic [1:0]                     HTRANS,
  output logic                           HMASTLOCK,
  input  logic [dbg_ahb_pkg::ahb_dw-1:0] HRDATA,
  input  logic                           HREADY,
  input  logic                           HRESP
);

  logic start_pulse;
  logic done_pulse;

  dbg_xfer_if xfer ();

  ////////////////////
  // Fixed AHB attributes
  assign HSEL      = 1'b1;
  assign HBURST    = dbg_ahb_pkg::hburst_single;
  assign HPROT     = dbg_ahb_pkg::hprot_dbg;
  assign HMASTLOCK = 1'b0;

  // Result is stable by the time bb_rdy rises
  assign bb_do  = xfer.rdata;
  assign bb_err = xfer.err;

  dbg_bb_capture capture0 (
    .tck          (tck),
    .ahb_rstn     (ahb_rstn),
    .bb_strb      (bb_strb),
    .bb_rw        (bb_rw),
    .bb_addr      (bb_addr),
    .bb_di        (bb_di),
    .bb_word_size (bb_word_size),
    .done_pulse   (done_pulse),
    .bb_rdy       (bb_rdy),
    .x            (xfer.tck_side)
  );

  // Both toggles sit low around reset, so the raw reset is safe here
  dbg_toggle_sync start_sync (
    .clk      (HCLK),
    .ahb_rstn (ahb_rstn),
    .tgl      (xfer.start_tgl),
    .pulse    (start_pulse)
  );

  dbg_toggle_sync done_sync (
    .clk      (tck),
    .ahb_rstn (ahb_rstn),
    .tgl      (xfer.done_tgl),
    .pulse    (done_pulse)
  );

  dbg_ahb_master master0 (
    .HCLK        (HCLK),
    .ahb_rstn    (ahb_rstn),
    .start_pulse (start_pulse),
    .x           (xfer.ahb_side),
    .HADDR       (HADDR),
    .HWDATA      (HWDATA),
    .HWRITE      (HWRITE),
    .HSIZE       (HSIZE),
    .HTRANS      (HTRANS),
    .HRDATA      (HRDATA),
    .HREADY      (HREADY),
    .HRESP       (HRESP)
  );

endmodule

// File: tb_ahb_slave.sv
/* AHB-Lite memory slave for the bridge testbench
   256-byte window, random wait states, error response on address bit 31 */

`timescale 1ns/1ps

module tb_ahb_slave (
  input  logic        HCLK,
  input  logic        ahb_rstn,
  input  logic        HSEL,
  input  logic [31:0] HADDR,
  input  logic [31:0] HWDATA,
  input  logic        HWRITE,
  input  logic [2:0]  HSIZE,
  input  logic [1:0]  HTRANS,
  output logic [31:0] HRDATA,
  output logic        HREADY,
  output logic        HRESP
);

  logic [7:0] mem [0:255];
  logic       dph;
  logic       err_q;
  logic       err_seen;
  logic [1:0] wcnt;
  logic [7:0] a_q;
  logic       w_q;
  logic [2:0] s_q;
  integer     seed;
  integer     r;
  int         k;

  // Start pattern, every byte a function of its full address
  function automatic logic [7:0] fill_byte(input logic [7:0] a);
    return (a * 8'd37) ^ 8'h5a;
  endfunction

  // Byte lanes touched by a write of this size at this offset
  function automatic logic lane_en(input logic [2:0] size, input logic [1:0] a,
                                   input logic [1:0] lane);
    case (size)
      dbg_ahb_pkg::hsize_byte: return lane == a;
      dbg_ahb_pkg::hsize_half: return lane[1] == a[1];
      default:                 return 1'b1;
    endcase
  endfunction

  initial begin
    seed = 32'he099_d173;
    for (k = 0; k < 256; k++) begin
      mem[k[7:0]] = fill_byte(k[7:0]);
    end
  end

  ////////////////////
  // Response signals
  // Error takes two cycles, first with HREADY low
  assign HREADY = !dph || (wcnt == 2'd0 && (!err_q || err_seen));
  assign HRESP  = dph && (wcnt == 2'd0) && err_q;
  assign HRDATA = {mem[{a_q[7:2], 2'd3}], mem[{a_q[7:2], 2'd2}],
                   mem[{a_q[7:2], 2'd1}], mem[{a_q[7:2], 2'd0}]};

  always @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      dph      <= 1'b0;
      err_q    <= 1'b0;
      err_seen <= 1'b0;
      wcnt     <= 2'd0;
      a_q      <= 8'd0;
      w_q      <= 1'b0;
      s_q      <= 3'd0;
    end else begin
      // Data phase: wait states, then error or completion
      if (dph) begin
        if (wcnt != 2'd0) begin
          wcnt <= wcnt - 2'd1;
        end else if (err_q && !err_seen) begin
          err_seen <= 1'b1;
        end else begin
          dph <= 1'b0;
          if (w_q && !err_q) begin
            for (k = 0; k < 4; k++) begin
              if (lane_en(s_q, a_q[1:0], k[1:0])) begin
                mem[{a_q[7:2], k[1:0]}] <= HWDATA[8 * k +: 8];
              end
            end
          end
        end
      end
      // New address phase
      if (HREADY && HSEL && HTRANS == dbg_ahb_pkg::htrans_nonseq) begin
        r        = $random(seed);
        dph      <= 1'b1;
        a_q      <= HADDR[7:0];
        w_q      <= HWRITE;
        s_q      <= HSIZE;
        err_q    <= HADDR[31];
        err_seen <= 1'b0;
        wcnt     <= r[1:0];
      end
    end
  end

endmodule

// File: dbg_ahb_props.sv
/* Bound checks on the AHB outputs of the debug bridge master */

`timescale 1ns/1ps

module dbg_ahb_props (
  input logic                           HCLK,
  input logic                           ahb_rstn,
  input logic [1:0]                     HTRANS,
  input logic                           HREADY,
  input logic [dbg_ahb_pkg::ahb_aw-1:0] HADDR,
  input logic                           HWRITE,
  input logic [2:0]                     HSIZE
);

  // Data phase follows every accepted NONSEQ
  logic dph;

  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      dph <= 1'b0;
    end else if (HREADY) begin
      dph <= (HTRANS == dbg_ahb_pkg::htrans_nonseq);
    end
  end

  ////////////////////
  // Only single transfers ever leave the master
  a_htrans_legal: assert property (@(posedge HCLK) disable iff (!ahb_rstn)
    HTRANS == dbg_ahb_pkg::htrans_idle || HTRANS == dbg_ahb_pkg::htrans_nonseq)
    else $error("HTRANS outside IDLE and NONSEQ");

  a_nonseq_single: assert property (@(posedge HCLK) disable iff (!ahb_rstn)
    HTRANS == dbg_ahb_pkg::htrans_nonseq |=> HTRANS != dbg_ahb_pkg::htrans_nonseq)
    else $error("NONSEQ held for two cycles");

  // Wait states freeze the control signals
  a_hold_in_wait: assert property (@(posedge HCLK) disable iff (!ahb_rstn)
    (dph && !HREADY) |=> ($stable(HADDR) && $stable(HWRITE) && $stable(HSIZE)))
    else $error("Address phase signals moved during a wait state");

endmodule

// File: tb_dbg_ahb_bridge.sv
/* Testbench for the debug bus to AHB-Lite bridge
   Random debug accesses checked against a byte-level reference memory */

`timescale 1ns/1ps

module tb_dbg_ahb_bridge;

  localparam int hclk_half   = 4;
  localparam int tck_half    = 13;
  localparam int n_access    = 300;
  localparam int n_directed  = 6;
  localparam int watchdog_ns = (n_access + n_directed) * 40 * 2 * tck_half;

  logic                  HCLK;
  logic                  tck;
  logic                  ahb_rstn;
  logic                  bb_strb;
  logic                  bb_rw;
  logic [31:0]           bb_addr;
  logic [31:0]           bb_di;
  dbg_bus_pkg::bb_size_t bb_word_size;
  logic                  bb_rdy;
  logic [31:0]           bb_do;
  logic                  bb_err;
  logic                  HSEL;
  logic [31:0]           HADDR;
  logic [31:0]           HWDATA;
  logic                  HWRITE;
  logic [2:0]            HSIZE;
  logic [2:0]            HBURST;
  logic [3:0]            HPROT;
  logic [1:0]            HTRANS;
  logic                  HMASTLOCK;
  logic [31:0]           HRDATA;
  logic                  HREADY;
  logic                  HRESP;

  // Reference memory and bookkeeping
  logic [7:0]  ref_mem [0:255];
  integer      seed;
  integer      r;
  int          i;
  int          n_done;
  int          xfers;
  int          xfer_base;
  int          rdy_rises;
  int          rise_base;
  logic        rdy_prev;
  logic        rw;
  int          nb;
  logic [7:0]  a;
  logic [31:0] addr;
  logic [31:0] di;

  dbg_ahb_bridge dut0 (.*);

  tb_ahb_slave slave0 (
    .HCLK(HCLK), .ahb_rstn(ahb_rstn), .HSEL(HSEL), .HADDR(HADDR), .HWDATA(HWDATA),
    .HWRITE(HWRITE), .HSIZE(HSIZE), .HTRANS(HTRANS), .HRDATA(HRDATA),
    .HREADY(HREADY), .HRESP(HRESP)
  );

  bind dbg_ahb_master dbg_ahb_props props0 (
    .HCLK(HCLK), .ahb_rstn(ahb_rstn), .HTRANS(HTRANS), .HREADY(HREADY),
    .HADDR(HADDR), .HWRITE(HWRITE), .HSIZE(HSIZE)
  );

  ////////////////////
  // Clocks
  initial begin
    HCLK = 1'b0;
    forever #(hclk_half) HCLK = ~HCLK;
  end

  initial begin
    tck = 1'b0;
    forever #(tck_half) tck = ~tck;
  end

  // Count accepted AHB transfers
  always @(posedge HCLK) begin
    if (ahb_rstn && HREADY && HTRANS == dbg_ahb_pkg::htrans_nonseq) begin
      xfers <= xfers + 1;
    end
  end

  // bb_rdy rising edges, seen on the sampling edge
  always @(negedge tck) begin
    rdy_prev <= bb_rdy;
    if (bb_rdy && !rdy_prev) begin
      rdy_rises <= rdy_rises + 1;
    end
  end

  ////////////////////
  // Helpers
  function automatic logic [7:0] fill_byte(input logic [7:0] a);
    return (a * 8'd37) ^ 8'h5a;
  endfunction

  function automatic dbg_bus_pkg::bb_size_t size_code(input int n);
    case (n)
      1:       return dbg_bus_pkg::ws_byte;
      2:       return dbg_bus_pkg::ws_half;
      default: return dbg_bus_pkg::ws_word;
    endcase
  endfunction

  // Little-endian, byte k of the access lives at address a + k
  function automatic logic [31:0] model_read(input logic [7:0] a, input int n);
    logic [31:0] v;
    int          k;
    v = 32'd0;
    for (k = 0; k < n; k++) begin
      v[8 * k +: 8] = ref_mem[a + k[7:0]];
    end
    return v;
  endfunction

  task automatic model_write(input logic [7:0] a, input int n, input logic [31:0] d);
    int k;
    for (k = 0; k < n; k++) begin
      ref_mem[a + k[7:0]] = d[8 * k +: 8];
    end
  endtask

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      $display("Simulation finished: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // One debug access, with an optional stray strobe while busy
  task automatic do_access(input logic rd, input logic [31:0] ad, input int n,
                           input logic [31:0] d, input logic extra);
    logic exp_err;
    exp_err = ad[31];
    @(negedge tck);
    check(32'(rdy_rises - rise_base), 32'(n_done), "bb_rdy rises per access");
    bb_strb      = 1'b1;
    bb_rw        = rd;
    bb_addr      = ad;
    bb_di        = d;
    bb_word_size = size_code(n);
    @(negedge tck);
    bb_strb = 1'b0;
    check(32'(bb_rdy), 32'd0, "bb_rdy low after accept");
    if (extra) begin
      // Busy, so this write must vanish
      bb_strb      = 1'b1;
      bb_rw        = 1'b0;
      bb_addr      = {24'd0, ~ad[7:2], 2'b00};
      bb_di        = ~d;
      bb_word_size = dbg_bus_pkg::ws_word;
      @(negedge tck);
      bb_strb = 1'b0;
    end
    while (!bb_rdy) begin
      @(negedge tck);
    end
    n_done++;
    check(32'(bb_err), 32'(exp_err), "bb_err");
    check(32'(xfers - xfer_base), 32'(n_done), "AHB transfers per access");
    if (rd && !exp_err) begin
      check(bb_do, model_read(ad[7:0], n), "bb_do");
    end else if (!rd && !exp_err) begin
      model_write(ad[7:0], n, d);
    end
  endtask

  ////////////////////
  // Watchdog
  initial begin
    #(watchdog_ns);
    $display("Watchdog expired: a debug access never saw bb_rdy return");
    $display("Simulation finished: FAIL");
    $fatal(1, "timeout");
  end

  ////////////////////
  // Main sequence
  initial begin
    seed         = 32'he099_d173;
    ahb_rstn     = 1'b0;
    bb_strb      = 1'b0;
    bb_rw        = 1'b1;
    bb_addr      = 32'd0;
    bb_di        = 32'd0;
    bb_word_size = dbg_bus_pkg::ws_word;
    n_done       = 0;
    for (i = 0; i < 256; i++) begin
      ref_mem[i[7:0]] = fill_byte(i[7:0]);
    end
    repeat (2) @(posedge HCLK);
    @(negedge HCLK);
    ahb_rstn = 1'b1;
    // Let both reset chains release
    repeat (4) @(negedge tck);
    check(32'(bb_rdy), 32'd1, "bb_rdy after reset");
    check(32'(bb_err), 32'd0, "bb_err after reset");
    check(32'(HTRANS), 32'(dbg_ahb_pkg::htrans_idle), "HTRANS after reset");
    check(32'(HWRITE), 32'd0, "HWRITE after reset");
    check({28'd0, HPROT}, 32'h3, "HPROT data privileged");
    check({29'd0, HBURST}, 32'd0, "HBURST single");
    check({30'd0, HSEL, HMASTLOCK}, 32'h2, "HSEL and HMASTLOCK");
    xfer_base = xfers;
    rise_base = rdy_rises;

    // Sized writes merged into one word, stray strobe, error in between
    do_access(1'b0, 32'h0000_0040, 4, 32'h1122_3344, 1'b0);
    do_access(1'b0, 32'h0000_0041, 1, 32'h0000_00aa, 1'b0);
    do_access(1'b0, 32'h0000_0042, 2, 32'h0000_beef, 1'b1);
    do_access(1'b0, 32'h8000_0040, 4, 32'hdead_0000, 1'b0);
    do_access(1'b1, 32'h0000_0040, 4, 32'd0, 1'b0);
    do_access(1'b1, 32'h0000_0043, 1, 32'd0, 1'b0);

    for (i = 0; i < n_access; i++) begin
      r  = $random(seed);
      rw = r[0];
      case (r[2:1])
        2'd0:    nb = 1;
        2'd1:    nb = 2;
        default: nb = 4;
      endcase
      a = r[15:8];
      if (nb == 2) begin
        a[0] = 1'b0;
      end else if (nb == 4) begin
        a[1:0] = 2'b00;
      end
      // Roughly one in eight hits the error region
      addr = {(r[18:16] == 3'd0), 23'd0, a};
      di   = $random(seed);
      do_access(rw, addr, nb, di, r[22:20] == 3'd0);
    end

    // Nothing late may show up after the last access
    repeat (20) @(negedge tck);
    check(32'(xfers - xfer_base), 32'(n_done), "total AHB transfers");
    check(32'(rdy_rises - rise_base), 32'(n_done), "total bb_rdy rises");
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// File: build.f
dbg_ahb_pkg.sv
dbg_bus_pkg.sv
dbg_xfer_if.sv
dbg_toggle_sync.sv
dbg_bb_capture.sv
dbg_ahb_master.sv
dbg_ahb_bridge.sv
tb_ahb_slave.sv
dbg_ahb_props.sv
tb_dbg_ahb_bridge.sv

// File: Makefile
# Verilator build and run of the debug bus to AHB-Lite bridge testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module tb_dbg_ahb_bridge -Mdir obj_dir -f build.f
	./obj_dir/Vtb_dbg_ahb_bridge

clean:
	rm -rf obj_dir
